// ==== logic/fft_macros.svh ====
// FFT size, stage count, sample and twiddle word widths, fraction bits

`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// ==============================
// Transform size
// ==============================

// Number of points per frame
`define FFT_POINTS 16

// Radix-2 stages, log2 of the point count
`define FFT_STAGES 4

// ==============================
// Fixed-point formats
// ==============================

// Real or imaginary sample part, Q10.6
`define SAMPLE_W 16

// Real or imaginary twiddle part, Q2.6
`define TWIDDLE_W 8

// Both formats share the same binary point
`define FRAC_BITS 6

`endif

// ==== logic/fft_pkg.sv ====
// FFT package with sample and twiddle types and the butterfly state enum

`default_nettype none

`include "fft_macros.svh"

package fft_pkg;

    // ==============================
    // Data types
    // ==============================

    // One real or imaginary part of a sample in Q10.6
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // One real or imaginary part of a twiddle factor in Q2.6
    typedef logic signed [`TWIDDLE_W-1:0] twiddle_t;

    // ==============================
    // Butterfly control
    // ==============================

    // Operating mode of an SDF butterfly within the 2D sample cycle
    typedef enum logic [1:0] {
        BFLY_IDLE    = 2'b00,
        BFLY_FIRST   = 2'b01,
        BFLY_SECOND  = 2'b10,
        BFLY_WAITING = 2'b11
    } bfly_state_e;

endpackage

`default_nettype wire

// ==== logic/sdf_butterfly.sv ====
// Combinational radix-2 SDF butterfly with state-selected outputs

`timescale 1ns/100ps
`default_nettype none

module sdf_butterfly (
    input  fft_pkg::bfly_state_e state_i,
    // New sample from the stage input
    input  fft_pkg::sample_t     a_re_i,
    input  fft_pkg::sample_t     a_im_i,
    // Oldest entry of the feedback delay line
    input  fft_pkg::sample_t     b_re_i,
    input  fft_pkg::sample_t     b_im_i,
    // Toward the twiddle multiplier and output register
    output fft_pkg::sample_t     out_re_o,
    output fft_pkg::sample_t     out_im_o,
    // Toward the head of the delay line
    output fft_pkg::sample_t     sr_re_o,
    output fft_pkg::sample_t     sr_im_o
);

    // A and B are x[n+D] and x[n] of the decimation-in-frequency pair.
    // Word growth wraps, since the datapath has no scaling or saturation
    always_comb begin
        case (state_i)
            // First half of a block fills the delay line
            fft_pkg::BFLY_WAITING: begin
                out_re_o = '0;
                out_im_o = '0;
                sr_re_o  = a_re_i;
                sr_im_o  = a_im_i;
            end
            // Sum leaves at once, difference goes round the loop again
            fft_pkg::BFLY_FIRST: begin
                out_re_o = a_re_i + b_re_i;
                out_im_o = a_im_i + b_im_i;
                sr_re_o  = b_re_i - a_re_i;
                sr_im_o  = b_im_i - a_im_i;
            end
            // Stored differences drain out while the next frame fills in behind them
            fft_pkg::BFLY_SECOND: begin
                out_re_o = b_re_i;
                out_im_o = b_im_i;
                sr_re_o  = a_re_i;
                sr_im_o  = a_im_i;
            end
            // Nothing moves
            default: begin
                out_re_o = '0;
                out_im_o = '0;
                sr_re_o  = '0;
                sr_im_o  = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/sdf_stage.sv ====
// Radix-2 SDF stage with delay line, state counters, twiddle ROM and multiplier

`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

module sdf_stage #(
    parameter int STAGE_IDX = 0
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             in_valid_i,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             out_valid_o,
    output fft_pkg::sample_t out_re_o,
    output fft_pkg::sample_t out_im_o
);

    // Feedback delay, half of the sub-transform length at this stage
    localparam int D     = `FFT_POINTS >> (STAGE_IDX + 1);
    localparam int CNT_W = $clog2(2 * D);
    localparam int SEC_W = $clog2(D + 1);
    localparam real PI   = 3.14159265358979;

    // Input position within the current 2D block
    logic [CNT_W-1:0] in_cnt;
    // SECOND cycles still owed to the previous block
    logic [SEC_W-1:0] sec_left;
    fft_pkg::bfly_state_e state;

    fft_pkg::sample_t dl_re [D];
    fft_pkg::sample_t dl_im [D];
    fft_pkg::sample_t bf_re;
    fft_pkg::sample_t bf_im;
    fft_pkg::sample_t sr_re;
    fft_pkg::sample_t sr_im;
    fft_pkg::sample_t mul_re;
    fft_pkg::sample_t mul_im;

    // Rounded Q2.6 part of W_N^power, evaluated only at elaboration
    function automatic fft_pkg::twiddle_t twiddle_part(input int power, input logic imag);
        real ang;
        real val;
        int  q;
        ang = -2.0 * PI * real'(power) / real'(`FFT_POINTS);
        val = imag ? $sin(ang) : $cos(ang);
        val = val * real'(1 << `FRAC_BITS);
        q   = (val >= 0.0) ? $rtoi(val + 0.5) : $rtoi(val - 0.5);
        return fft_pkg::twiddle_t'(q);
    endfunction

    // ==============================
    // Control
    // ==============================

    // Pending SECOND cycles win over WAITING so that frames may abut
    always_comb begin
        if (in_valid_i && in_cnt[CNT_W-1]) begin
            state = fft_pkg::BFLY_FIRST;
        end else if (sec_left != '0) begin
            state = fft_pkg::BFLY_SECOND;
        end else if (in_valid_i) begin
            state = fft_pkg::BFLY_WAITING;
        end else begin
            state = fft_pkg::BFLY_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_cnt   <= '0;
            sec_left <= '0;
        end else begin
            if (in_valid_i) begin
                in_cnt <= in_cnt + 1'b1;
            end
            // The last FIRST sample arms D cycles of SECOND
            if (state == fft_pkg::BFLY_FIRST && (&in_cnt)) begin
                sec_left <= SEC_W'(D);
            end else if (sec_left != '0) begin
                sec_left <= sec_left - 1'b1;
            end
        end
    end

    // ==============================
    // Datapath
    // ==============================

    sdf_butterfly u_bfly (
        .state_i  (state),
        .a_re_i   (in_re_i),
        .a_im_i   (in_im_i),
        .b_re_i   (dl_re[D-1]),
        .b_im_i   (dl_im[D-1]),
        .out_re_o (bf_re),
        .out_im_o (bf_im),
        .sr_re_o  (sr_re),
        .sr_im_o  (sr_im)
    );

    // Delay line advances on every active cycle, including idle-input SECOND
    always_ff @(posedge clk_i) begin
        if (state != fft_pkg::BFLY_IDLE) begin
            dl_re[0] <= sr_re;
            dl_im[0] <= sr_im;
            for (int i = 1; i < D; i++) begin
                dl_re[i] <= dl_re[i-1];
                dl_im[i] <= dl_im[i-1];
            end
        end
    end

    if (D > 1) begin : g_twiddle
        localparam int IDX_W = $clog2(D);
        localparam int ACC_W = `SAMPLE_W + `TWIDDLE_W + 1;
        localparam logic signed [ACC_W-1:0] HALF_LSB = ACC_W'(1) <<< (`FRAC_BITS - 1);

        logic [IDX_W-1:0] tw_idx;
        fft_pkg::twiddle_t rom_re [D];
        fft_pkg::twiddle_t rom_im [D];
        logic signed [ACC_W-1:0] acc_re;
        logic signed [ACC_W-1:0] acc_im;

        // Position j inside SECOND selects W_N^(j * 2^k)
        for (genvar g = 0; g < D; g++) begin : g_rom
            assign rom_re[g] = twiddle_part(g << STAGE_IDX, 1'b0);
            assign rom_im[g] = twiddle_part(g << STAGE_IDX, 1'b1);
        end

        assign tw_idx = IDX_W'(SEC_W'(D) - sec_left);

        // Complex product, then round half up back to Q10.6
        always_comb begin
            acc_re = bf_re * rom_re[tw_idx] - bf_im * rom_im[tw_idx] + HALF_LSB;
            acc_im = bf_re * rom_im[tw_idx] + bf_im * rom_re[tw_idx] + HALF_LSB;
        end

        assign mul_re = acc_re[`FRAC_BITS +: `SAMPLE_W];
        assign mul_im = acc_im[`FRAC_BITS +: `SAMPLE_W];
    end else begin : g_unity
        // Last stage only ever sees W^0
        assign mul_re = bf_re;
        assign mul_im = bf_im;
    end

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= (state == fft_pkg::BFLY_FIRST) || (state == fft_pkg::BFLY_SECOND);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == fft_pkg::BFLY_SECOND) begin
            out_re_o <= mul_re;
            out_im_o <= mul_im;
        end else begin
            out_re_o <= bf_re;
            out_im_o <= bf_im;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fft_frame_feeder.sv ====
// Input register and frame counter that pads broken frames with zeros

`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

module fft_frame_feeder (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             in_valid_i,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             data_valid_o,
    output fft_pkg::sample_t data_re_o,
    output fft_pkg::sample_t data_im_o,
    output logic             frame_padded_o
);

    localparam int POS_W = $clog2(`FFT_POINTS);

    // Slot index of the next sample within the frame
    logic [POS_W-1:0] pos;
    // Set while the rest of a broken frame is filled with zeros
    logic             padding;
    logic             pad_now;

    // A gap in the middle of a frame starts padding, and input is dropped until it ends
    assign pad_now = padding || (pos != '0 && !in_valid_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pos            <= '0;
            padding        <= 1'b0;
            data_valid_o   <= 1'b0;
            frame_padded_o <= 1'b0;
        end else begin
            data_valid_o   <= pad_now || in_valid_i;
            frame_padded_o <= pad_now && !padding;
            padding        <= pad_now && !(&pos);
            if (pad_now || in_valid_i) begin
                pos <= pos + 1'b1;
            end
        end
    end

    // Sample payload, zero while padding
    always_ff @(posedge clk_i) begin
        data_re_o <= pad_now ? '0 : in_re_i;
        data_im_o <= pad_now ? '0 : in_im_i;
    end

endmodule

`default_nettype wire

// ==== logic/fft_bit_reverse.sv ====
// Ping-pong reorder buffer from bit-reversed to natural bin order

`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

module fft_bit_reverse (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             in_valid_i,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             out_valid_o,
    output fft_pkg::sample_t out_re_o,
    output fft_pkg::sample_t out_im_o
);

    localparam int ADDR_W = $clog2(`FFT_POINTS);

    // Two banks, selected by the top address bit
    fft_pkg::sample_t mem_re [2 * `FFT_POINTS];
    fft_pkg::sample_t mem_im [2 * `FFT_POINTS];

    logic [ADDR_W-1:0] wcnt;
    logic              wbank;
    logic [ADDR_W-1:0] rcnt;
    logic              rbank;
    logic              rd_active;
    logic              last_write;

    function automatic logic [ADDR_W-1:0] bit_rev(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] rev;
        for (int i = 0; i < ADDR_W; i++) begin
            rev[i] = addr[ADDR_W-1-i];
        end
        return rev;
    endfunction

    assign last_write = in_valid_i && (&wcnt);

    // ==============================
    // Write side
    // ==============================

    // SDF output index n holds bin bitrev(n), so store it there
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            mem_re[{wbank, bit_rev(wcnt)}] <= in_re_i;
            mem_im[{wbank, bit_rev(wcnt)}] <= in_im_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wcnt  <= '0;
            wbank <= 1'b0;
        end else if (in_valid_i) begin
            wcnt <= wcnt + 1'b1;
            if (&wcnt) begin
                wbank <= ~wbank;
            end
        end
    end

    // ==============================
    // Read side
    // ==============================

    // A finished bank takes over at once, even if the last read just ended
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_active   <= 1'b0;
            rcnt        <= '0;
            rbank       <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= rd_active;
            if (last_write) begin
                rd_active <= 1'b1;
                rcnt      <= '0;
                rbank     <= wbank;
            end else if (rd_active) begin
                rcnt <= rcnt + 1'b1;
                if (&rcnt) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        out_re_o <= mem_re[{rbank, rcnt}];
        out_im_o <= mem_im[{rbank, rcnt}];
    end

endmodule

`default_nettype wire

// ==== logic/fft_r2sdf_top.sv ====
// Top level of the 16-point radix-2 SDF FFT with feeder, stages and reorder buffer

`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

module fft_r2sdf_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             in_valid_i,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             out_valid_o,
    output fft_pkg::sample_t out_re_o,
    output fft_pkg::sample_t out_im_o,
    output logic             frame_padded_o
);

    // Element 0 comes from the feeder, element k+1 from stage k
    logic             chain_valid [`FFT_STAGES+1];
    fft_pkg::sample_t chain_re    [`FFT_STAGES+1];
    fft_pkg::sample_t chain_im    [`FFT_STAGES+1];

    fft_frame_feeder u_feeder (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_re_i        (in_re_i),
        .in_im_i        (in_im_i),
        .data_valid_o   (chain_valid[0]),
        .data_re_o      (chain_re[0]),
        .data_im_o      (chain_im[0]),
        .frame_padded_o (frame_padded_o)
    );

    // Delays halve from stage to stage
    for (genvar k = 0; k < `FFT_STAGES; k++) begin : g_stage
        sdf_stage #(
            .STAGE_IDX (k)
        ) u_stage (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .in_valid_i  (chain_valid[k]),
            .in_re_i     (chain_re[k]),
            .in_im_i     (chain_im[k]),
            .out_valid_o (chain_valid[k+1]),
            .out_re_o    (chain_re[k+1]),
            .out_im_o    (chain_im[k+1])
        );
    end

    fft_bit_reverse u_reorder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (chain_valid[`FFT_STAGES]),
        .in_re_i     (chain_re[`FFT_STAGES]),
        .in_im_i     (chain_im[`FFT_STAGES]),
        .out_valid_o (out_valid_o),
        .out_re_o    (out_re_o),
        .out_im_o    (out_im_o)
    );

endmodule

`default_nettype wire

// ==== test/fft_ref_model.svh ====
// Real-valued DFT reference of one frame, bin tolerance and compare helpers for the testbench

`ifndef FFT_REF_MODEL_SVH
`define FFT_REF_MODEL_SVH

localparam real REF_PI = 3.14159265358979;

// One time-domain frame in sample LSB units
int  ref_x_re [`FFT_POINTS];
int  ref_x_im [`FFT_POINTS];

// Its spectrum in the same units, since the datapath does not scale
real ref_bin_re [`FFT_POINTS];
real ref_bin_im [`FFT_POINTS];
real ref_peak;

// Forward DFT, X[k] = sum of x[n] * exp(-j*2*pi*k*n/N)
task automatic compute_dft();
    real ang;
    real c;
    real s;
    real mag;
    ref_peak = 0.0;
    for (int k = 0; k < `FFT_POINTS; k++) begin
        ref_bin_re[k] = 0.0;
        ref_bin_im[k] = 0.0;
        for (int n = 0; n < `FFT_POINTS; n++) begin
            // Reducing k*n mod N keeps the angle small and the cosines exact at zero
            ang = -2.0 * REF_PI * real'((k * n) % `FFT_POINTS) / real'(`FFT_POINTS);
            c = $cos(ang);
            s = $sin(ang);
            ref_bin_re[k] = ref_bin_re[k] + real'(ref_x_re[n]) * c - real'(ref_x_im[n]) * s;
            ref_bin_im[k] = ref_bin_im[k] + real'(ref_x_re[n]) * s + real'(ref_x_im[n]) * c;
        end
        mag = $sqrt(ref_bin_re[k] * ref_bin_re[k] + ref_bin_im[k] * ref_bin_im[k]);
        if (mag > ref_peak) begin
            ref_peak = mag;
        end
    end
endtask

// Twiddle rounding grows with the size of the frame
function automatic real bin_tolerance();
    return 2.0 + 0.02 * ref_peak;
endfunction

function automatic int round_to_int(input real v);
    return (v >= 0.0) ? $rtoi(v + 0.5) : $rtoi(v - 0.5);
endfunction

// A tolerance of zero asks for the exact integer, small float noise aside
function automatic bit bin_matches(input real expected, input int actual, input real tol);
    real diff;
    diff = real'(actual) - expected;
    if (diff < 0.0) begin
        diff = -diff;
    end
    return diff <= tol + 0.001;
endfunction

`endif

// ==== test/fft_tb.sv ====
// Testbench for the SDF FFT with idle, exact, random, back-to-back and padded frames

`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

module fft_tb;

    // From the first input strobe of a frame to its first output bin
    localparam int LATENCY    = 2 * `FFT_POINTS + `FFT_STAGES + 1;
    localparam int WAIT_LIMIT = 200;

    logic             clk_i;
    logic             rst_n_i;
    logic             in_valid_i;
    fft_pkg::sample_t in_re_i;
    fft_pkg::sample_t in_im_i;
    logic             out_valid_o;
    fft_pkg::sample_t out_re_o;
    fft_pkg::sample_t out_im_o;
    logic             frame_padded_o;

    int seed;
    int cycle = 0;
    int errors;
    int checks;
    int tests;
    int test_errors;
    int pad_pulses = 0;
    int pad_cycle = 0;
    int pads_before;
    int frame_start;

    // Samples for the next frame
    int next_re [`FFT_POINTS];
    int next_im [`FFT_POINTS];

    // Frames in flight as the FFT sees them, padding included
    int sent_re_q[$];
    int sent_im_q[$];
    int start_q[$];

    // Output bins with the cycle they were seen in
    int got_re_q[$];
    int got_im_q[$];
    int got_cyc_q[$];

    `include "fft_ref_model.svh"

    fft_r2sdf_top dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_re_i        (in_re_i),
        .in_im_i        (in_im_i),
        .out_valid_o    (out_valid_o),
        .out_re_o       (out_re_o),
        .out_im_o       (out_im_o),
        .frame_padded_o (frame_padded_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // Outputs are sampled half a period after the edge that updates them
    always @(negedge clk_i) begin
        if (rst_n_i && out_valid_o) begin
            got_re_q.push_back(int'(out_re_o));
            got_im_q.push_back(int'(out_im_o));
            got_cyc_q.push_back(cycle);
        end
        if (rst_n_i && frame_padded_o) begin
            pad_pulses = pad_pulses + 1;
            pad_cycle  = cycle;
        end
    end

    // ==============================
    // Protocol assertions
    // ==============================

    assert property (@(posedge clk_i) disable iff (!rst_n_i) frame_padded_o |=> !frame_padded_o)
        else begin
            errors = errors + 1;
            $display("frame_padded_o stayed high longer than one cycle at cycle %0d", cycle);
        end

    assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o && !frame_padded_o)
        else begin
            errors = errors + 1;
            $display("Reset did not clear the output strobes at cycle %0d", cycle);
        end

    // Inputs change 2 ns after the edge, away from the sampling edge
    task automatic drive(input logic valid, input int re, input int im);
        @(posedge clk_i);
        #2;
        in_valid_i = valid;
        in_re_i    = fft_pkg::sample_t'(re);
        in_im_i    = fft_pkg::sample_t'(im);
    endtask

    task automatic fill_random();
        for (int i = 0; i < `FFT_POINTS; i++) begin
            next_re[i] = $random(seed) % 33;
            next_im[i] = $random(seed) % 33;
        end
    endtask

    // Frame cut off after n_keep samples, so the feeder has to pad the rest
    task automatic send_frame(input int n_keep);
        for (int i = 0; i < `FFT_POINTS; i++) begin
            if (i < n_keep) begin
                drive(1'b1, next_re[i], next_im[i]);
                sent_re_q.push_back(next_re[i]);
                sent_im_q.push_back(next_im[i]);
            end else begin
                // Two junk strobes inside the padding, which the feeder drops
                drive(i >= n_keep + 2 && i < n_keep + 4, 999, -999);
                sent_re_q.push_back(0);
                sent_im_q.push_back(0);
            end
            if (i == 0) begin
                start_q.push_back(cycle);
            end
        end
    endtask

    task automatic report_value(input string name, input int bin, input int exp, input int act);
        errors = errors + 1;
        $display("ERROR %s bin %0d: expected 0x%h, got 0x%h", name, bin, 16'(exp), 16'(act));
    endtask

    // Compares the oldest frame in flight with its DFT, bin by bin, in natural order
    task automatic check_frame(input bit exact);
        int  waited;
        int  act_re;
        int  act_im;
        int  cyc;
        real tol;
        for (int n = 0; n < `FFT_POINTS; n++) begin
            ref_x_re[n] = sent_re_q.pop_front();
            ref_x_im[n] = sent_im_q.pop_front();
        end
        frame_start = start_q.pop_front();
        compute_dft();
        tol = exact ? 0.0 : bin_tolerance();
        waited = 0;
        while (got_re_q.size() < `FFT_POINTS && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (got_re_q.size() < `FFT_POINTS) begin
            errors = errors + 1;
            $display("Timeout after %0d cycles with only %0d of %0d bins out",
                     waited, got_re_q.size(), `FFT_POINTS);
        end else begin
            for (int k = 0; k < `FFT_POINTS; k++) begin
                act_re = got_re_q.pop_front();
                act_im = got_im_q.pop_front();
                cyc    = got_cyc_q.pop_front();
                checks = checks + 3;
                assert (bin_matches(ref_bin_re[k], act_re, tol))
                    else report_value("out_re_o", k, round_to_int(ref_bin_re[k]), act_re);
                assert (bin_matches(ref_bin_im[k], act_im, tol))
                    else report_value("out_im_o", k, round_to_int(ref_bin_im[k]), act_im);
                // Bins leave one per cycle after the fixed latency
                assert (cyc == frame_start + LATENCY + k)
                    else begin
                        errors = errors + 1;
                        $display("Bin %0d came out %0d cycles after the frame start, not %0d",
                                 k, cyc - frame_start, LATENCY + k);
                    end
            end
        end
    endtask

    task automatic end_test(input string name);
        tests = tests + 1;
        $display("Test %s %s with %0d errors", name,
                 (errors == test_errors) ? "passed" : "failed", errors - test_errors);
        test_errors = errors;
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        seed        = 32'hda8d;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_re_i     = '0;
        in_im_i     = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        // No input, so nothing may come out
        for (int i = 0; i < 2 * LATENCY; i++) begin
            @(negedge clk_i);
            checks = checks + 2;
            assert (!out_valid_o)
                else report_value("out_valid_o", cycle, 0, int'(out_valid_o));
            assert (!frame_padded_o)
                else report_value("frame_padded_o", cycle, 0, int'(frame_padded_o));
        end
        end_test("reset_idle");

        // Bin 0 holds 16 times the constant, the rest is zero
        for (int i = 0; i < `FFT_POINTS; i++) begin
            next_re[i] = 100;
            next_im[i] = -37;
        end
        send_frame(`FFT_POINTS);
        drive(1'b0, 0, 0);
        check_frame(1'b1);
        end_test("constant");

        // A flat spectrum equal to the impulse
        for (int i = 0; i < `FFT_POINTS; i++) begin
            next_re[i] = 0;
            next_im[i] = 0;
        end
        next_re[0] = 300;
        next_im[0] = -150;
        send_frame(`FFT_POINTS);
        drive(1'b0, 0, 0);
        check_frame(1'b1);
        end_test("impulse");

        for (int r = 0; r < 4; r++) begin
            fill_random();
            send_frame(`FFT_POINTS);
            drive(1'b0, 0, 0);
            check_frame(1'b0);
        end
        end_test("random");

        // Three frames without a gap between them
        pads_before = pad_pulses;
        for (int f = 0; f < 3; f++) begin
            fill_random();
            send_frame(`FFT_POINTS);
        end
        drive(1'b0, 0, 0);
        for (int f = 0; f < 3; f++) begin
            check_frame(1'b0);
        end
        checks = checks + 1;
        assert (pad_pulses == pads_before)
            else report_value("frame_padded_o", 0, 0, pad_pulses - pads_before);
        end_test("back_to_back");

        // Cut after 10 samples, first padded slot leaves the feeder at slot 10
        pads_before = pad_pulses;
        fill_random();
        send_frame(10);
        drive(1'b0, 0, 0);
        check_frame(1'b0);
        checks = checks + 2;
        assert (pad_pulses == pads_before + 1)
            else report_value("frame_padded_o", 10, 1, pad_pulses - pads_before);
        assert (pad_cycle == frame_start + 10 + 1)
            else begin
                errors = errors + 1;
                $display("frame_padded_o pulsed %0d cycles after the frame start, not 11",
                         pad_cycle - frame_start);
            end
        end_test("padding");

        // Nothing beyond the checked frames may come out
        repeat (LATENCY) @(posedge clk_i);
        checks = checks + 1;
        assert (got_re_q.size() == 0)
            else report_value("out_valid_o", 0, 0, got_re_q.size());

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
+incdir+test
logic/fft_pkg.sv
logic/sdf_butterfly.sv
logic/sdf_stage.sv
logic/fft_frame_feeder.sv
logic/fft_bit_reverse.sv
logic/fft_r2sdf_top.sv
test/fft_tb.sv

// ==== Bender.yml ====
package:
  name: fft_r2sdf

sources:
  - include_dirs:
      - logic
    files:
      - logic/fft_pkg.sv
      - logic/sdf_butterfly.sv
      - logic/sdf_stage.sv
      - logic/fft_frame_feeder.sv
      - logic/fft_bit_reverse.sv
      - logic/fft_r2sdf_top.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/fft_tb.sv
